//--- hdl/anchor_fetch.sv
// anchor fetcher: walks the anchor sram range one read per cycle with fifo back-pressure
`timescale 1ns/100ps
`include "occl_settings.svh"

module anchor_fetch (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start_i,
    input  occl_pkg::anchor_addr_t            addr_start_i,
    input  occl_pkg::anchor_addr_t            addr_end_i,
    input  logic [$clog2(`OCCL_FIFO_DEPTH):0] fifo_count_i,
    output logic                              rd_cen_n_o,
    output occl_pkg::anchor_addr_t            rd_addr_o,
    output logic                              range_done_o,
    output logic                              busy_o
);
    import occl_pkg::*;

    localparam int CNT_W   = $clog2(`OCCL_FIFO_DEPTH) + 1;
    localparam int DRAIN_W = $clog2(`OCCL_PIPE_SLACK);
    localparam logic [CNT_W-1:0]   STALL_LVL = CNT_W'(`OCCL_FIFO_DEPTH - `OCCL_PIPE_SLACK);
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`OCCL_PIPE_SLACK - 1);

    fetch_state_t       state;
    anchor_addr_t       addr_q;
    anchor_addr_t       end_q;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               stall;
    logic               rd_fire;
    logic               last_rd;
    logic               drain_end;

    // keep room in the fifo for everything already in the pipe
    assign stall     = fifo_count_i >= STALL_LVL;
    assign rd_fire   = (state == READ) && !stall;
    assign last_rd   = rd_fire && (addr_q == end_q);
    assign drain_end = (state == DRAIN) && (drain_cnt == DRAIN_LAST);

    assign rd_cen_n_o   = !rd_fire;
    assign rd_addr_o    = addr_q;
    assign range_done_o = drain_end;
    assign busy_o       = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IDLE;
            drain_cnt <= '0;
            addr_q    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state  <= READ;
                        addr_q <= addr_start_i;
                    end
                end
                READ: begin
                    if (last_rd) begin
                        state <= DRAIN;
                    end else if (rd_fire) begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
        end
    end

    // end address held for the whole pass
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            end_q <= addr_end_i;
        end
    end

endmodule

//--- hdl/anchor_project.sv
// anchor projector: three-stage pipe from anchor coordinates to grid cell address, lane and depth
`timescale 1ns/100ps
`include "occl_settings.svh"

module anchor_project (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rd_fire_i,
    input  occl_pkg::anchor_t anchor_i,
    input  occl_pkg::focal_t  focal_i,
    output logic              cell_valid_o,
    output occl_pkg::cell_t   cell_o,
    output logic              in_flight_o
);
    import occl_pkg::*;

    localparam int MAG_W  = `OCCL_COORD_W - 1;
    localparam int PROD_W = MAG_W + `OCCL_FOCAL_W;
    localparam int BIN_W  = MAG_W - `OCCL_FRAC_W;  // integer part of z
    localparam int POS_W  = $clog2(`OCCL_GRID_DIM);
    localparam logic [POS_W-1:0]  CTR     = POS_W'(`OCCL_GRID_CENTER);
    localparam logic [PROD_W-1:0] NEG_LIM = PROD_W'(`OCCL_GRID_CENTER);
    localparam logic [PROD_W-1:0] POS_LIM = PROD_W'(`OCCL_GRID_DIM - `OCCL_GRID_CENTER - 1);

    logic              fire_d;  // data valid on anchor_i

    logic              s1_v;
    logic [PROD_W-1:0] s1_px;
    logic [PROD_W-1:0] s1_py;
    logic              s1_sx;
    logic              s1_sy;
    coord_t            s1_z;

    logic              s2_v;
    logic [PROD_W-1:0] s2_qx;
    logic [PROD_W-1:0] s2_qy;
    logic              s2_sx;
    logic              s2_sy;
    depth_t            s2_bin;
    logic              s2_bin_ok;

    logic [PROD_W-1:0] div;
    logic [BIN_W-1:0]  zint;
    logic [POS_W-1:0]  col;
    logic [POS_W-1:0]  row;
    logic              col_ok;
    logic              row_ok;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fire_d       <= 1'b0;
            s1_v         <= 1'b0;
            s2_v         <= 1'b0;
            cell_valid_o <= 1'b0;
        end else begin
            fire_d       <= rd_fire_i;
            s1_v         <= fire_d;
            s2_v         <= s1_v;
            cell_valid_o <= s2_v && col_ok && row_ok && s2_bin_ok;
        end
    end

    // stage 1: scale magnitudes by focal
    always_ff @(posedge clk) begin
        s1_px <= PROD_W'(anchor_i.x[MAG_W-1:0]) * PROD_W'(focal_i);
        s1_py <= PROD_W'(anchor_i.y[MAG_W-1:0]) * PROD_W'(focal_i);
        s1_sx <= anchor_i.x[MAG_W];
        s1_sy <= anchor_i.y[MAG_W];
        s1_z  <= anchor_i.z;
    end

    // stage 2: divide by z, fraction bits cancel out
    assign div  = (s1_z[MAG_W-1:0] == '0) ? PROD_W'(1) : PROD_W'(s1_z[MAG_W-1:0]);
    assign zint = s1_z[MAG_W-1:`OCCL_FRAC_W];

    always_ff @(posedge clk) begin
        s2_qx     <= s1_px / div;
        s2_qy     <= s1_py / div;
        s2_sx     <= s1_sx;
        s2_sy     <= s1_sy;
        s2_bin    <= zint[`OCCL_DEPTH_W-1:0];
        // negative z or bin outside 1..255 is behind or too far
        s2_bin_ok <= !s1_z[MAG_W] && (zint != '0) && (zint[BIN_W-1:`OCCL_DEPTH_W] == '0);
    end

    // stage 3: offset from center and range test
    assign col_ok = s2_sx ? (s2_qx <= NEG_LIM) : (s2_qx <= POS_LIM);
    assign row_ok = s2_sy ? (s2_qy <= NEG_LIM) : (s2_qy <= POS_LIM);
    assign col    = s2_sx ? CTR - s2_qx[POS_W-1:0] : CTR + s2_qx[POS_W-1:0];
    assign row    = s2_sy ? CTR - s2_qy[POS_W-1:0] : CTR + s2_qy[POS_W-1:0];

    always_ff @(posedge clk) begin
        cell_o.addr  <= block_addr_t'(row * `OCCL_WORDS_PER_ROW + col / `OCCL_LANES);
        cell_o.lane  <= lane_t'(col % `OCCL_LANES);
        cell_o.depth <= s2_bin;
    end

    assign in_flight_o = fire_d || s1_v || s2_v || cell_valid_o;

endmodule

//--- hdl/cell_fifo.sv
// cell FIFO: register-array buffer of projected cells with fill level for back-pressure
`timescale 1ns/100ps
`include "occl_settings.svh"

module cell_fifo (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              push_i,
    input  occl_pkg::cell_t                   cell_i,
    input  logic                              pop_i,
    output occl_pkg::cell_t                   cell_o,
    output logic                              empty_o,
    output logic [$clog2(`OCCL_FIFO_DEPTH):0] count_o
);
    import occl_pkg::*;

    localparam int PTR_W = $clog2(`OCCL_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_LVL = (PTR_W + 1)'(`OCCL_FIFO_DEPTH);

    cell_t            mem [`OCCL_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && (count != FULL_LVL);
    assign do_pop  = pop_i && (count != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= cell_i;
        end
    end

    assign cell_o  = mem[rd_ptr];   // head visible without pop
    assign empty_o = (count == '0);
    assign count_o = count;

endmodule

//--- hdl/depth_merge.sv
// depth merger: read-modify-write of one block sram word per cell, nearest depth wins
`timescale 1ns/100ps
`include "occl_settings.svh"

module depth_merge (
    input  logic                  clk,
    input  logic                  rstn,
    input  occl_pkg::cell_t       cell_i,
    input  logic                  empty_i,
    output logic                  pop_o,
    output occl_pkg::blk_req_t    blk_req_o,
    input  occl_pkg::block_word_t blk_rdata_i,
    output logic                  idle_o
);
    import occl_pkg::*;

    localparam int CELL_W = `OCCL_DEPTH_W + 1;  // valid + depth

    logic              wr_phase;
    cell_t             cell_q;
    logic [CELL_W-1:0] old_cell;
    logic [CELL_W-1:0] new_cell;
    logic              take;
    block_word_t       merged;

    // read cycle pops the head, write cycle follows
    assign pop_o  = !wr_phase && !empty_i;
    assign idle_o = !wr_phase;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_phase <= 1'b0;
        end else begin
            wr_phase <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            cell_q <= cell_i;
        end
    end

    assign old_cell = blk_rdata_i[cell_q.lane * CELL_W +: CELL_W];

    // empty lane or a nearer anchor
    assign take     = !old_cell[CELL_W-1] || (cell_q.depth < old_cell[`OCCL_DEPTH_W-1:0]);
    assign new_cell = take ? {1'b1, cell_q.depth} : old_cell;

    always_comb begin
        merged = blk_rdata_i;  // other lanes and the spare top bit pass through
        merged[cell_q.lane * CELL_W +: CELL_W] = new_cell;
    end

    always_comb begin
        blk_req_o.cen_n = !(pop_o || wr_phase);
        blk_req_o.wen   = wr_phase;
        blk_req_o.addr  = wr_phase ? cell_q.addr : cell_i.addr;
        blk_req_o.wdata = wr_phase ? merged : '0;
    end

endmodule

//--- hdl/occl_grid_top.sv
// occlusion grid top: fetcher, projector, cell FIFO and depth merger with completion tracking
`timescale 1ns/100ps
`include "occl_settings.svh"

module occl_grid_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start_i,
    input  occl_pkg::anchor_addr_t addr_start_i,
    input  occl_pkg::anchor_addr_t addr_end_i,
    input  occl_pkg::focal_t       focal_i,
    output logic                   anchor_cen_n_o,
    output occl_pkg::anchor_addr_t anchor_addr_o,
    input  occl_pkg::anchor_t      anchor_data_i,
    output occl_pkg::blk_req_t     blk_req_o,
    input  occl_pkg::block_word_t  blk_rdata_i,
    output logic                   busy_o,
    output logic                   done_o
);
    import occl_pkg::*;

    logic                              fetch_start;
    logic                              fetch_busy;
    logic                              range_done;
    logic                              rd_fire;
    logic                              cell_valid;
    logic                              in_flight;
    cell_t                             proj_cell;
    cell_t                             head_cell;
    logic                              fifo_empty;
    logic [$clog2(`OCCL_FIFO_DEPTH):0] fifo_count;
    logic                              pop;
    logic                              merge_idle;
    logic                              range_seen;  // all reads issued, waiting on the tail
    logic                              drained;

    assign fetch_start = start_i && !busy_o;   // start while busy is dropped
    assign rd_fire     = !anchor_cen_n_o;

    anchor_fetch u_fetch (
        .clk          (clk),
        .rstn         (rstn),
        .start_i      (fetch_start),
        .addr_start_i (addr_start_i),
        .addr_end_i   (addr_end_i),
        .fifo_count_i (fifo_count),
        .rd_cen_n_o   (anchor_cen_n_o),
        .rd_addr_o    (anchor_addr_o),
        .range_done_o (range_done),
        .busy_o       (fetch_busy)
    );

    anchor_project u_project (
        .clk          (clk),
        .rstn         (rstn),
        .rd_fire_i    (rd_fire),
        .anchor_i     (anchor_data_i),
        .focal_i      (focal_i),
        .cell_valid_o (cell_valid),
        .cell_o       (proj_cell),
        .in_flight_o  (in_flight)
    );

    cell_fifo u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .push_i  (cell_valid),
        .cell_i  (proj_cell),
        .pop_i   (pop),
        .cell_o  (head_cell),
        .empty_o (fifo_empty),
        .count_o (fifo_count)
    );

    depth_merge u_merge (
        .clk         (clk),
        .rstn        (rstn),
        .cell_i      (head_cell),
        .empty_i     (fifo_empty),
        .pop_o       (pop),
        .blk_req_o   (blk_req_o),
        .blk_rdata_i (blk_rdata_i),
        .idle_o      (merge_idle)
    );

    assign drained = range_seen && !in_flight && fifo_empty && merge_idle;
    assign busy_o  = fetch_busy || range_seen;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            range_seen <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= drained;  // single pulse, range_seen clears with it
            if (range_done) begin
                range_seen <= 1'b1;
            end else if (drained) begin
                range_seen <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/occl_pkg.sv
// occlusion grid package: vector types, anchor/cell/request structs and the fetch FSM states
`include "occl_settings.svh"

package occl_pkg;

    typedef logic [`OCCL_COORD_W-1:0]   coord_t;    // [15] sign, [14:0] magnitude
    typedef logic [`OCCL_ANCHOR_AW-1:0] anchor_addr_t;
    typedef logic [`OCCL_BLOCK_AW-1:0]  block_addr_t;
    typedef logic [`OCCL_BLOCK_DW-1:0]  block_word_t;
    typedef logic [`OCCL_DEPTH_W-1:0]   depth_t;
    typedef logic [2:0]                 lane_t;
    typedef logic [`OCCL_FOCAL_W-1:0]   focal_t;

    // anchor sram word
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } anchor_t;

    // one projected cell
    typedef struct packed {
        block_addr_t addr;
        lane_t       lane;
        depth_t      depth;
    } cell_t;

    // block sram request, wen high = write
    typedef struct packed {
        logic        cen_n;
        logic        wen;
        block_addr_t addr;
        block_word_t wdata;
    } blk_req_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } fetch_state_t;

endpackage

//--- hdl/occl_settings.svh
// occlusion grid settings: grid geometry, data widths, block word packing and FIFO sizing
`ifndef OCCL_SETTINGS_SVH
`define OCCL_SETTINGS_SVH

// grid geometry
`define OCCL_GRID_DIM       20
`define OCCL_GRID_CENTER    10

// sign-magnitude anchor coordinates
`define OCCL_COORD_W        16
`define OCCL_FRAC_W         6   // fraction bits of a coordinate
`define OCCL_ANCHOR_AW      10

// block sram, 7 cells of valid + depth per word
`define OCCL_BLOCK_AW       6
`define OCCL_BLOCK_DW       64
`define OCCL_LANES          7
`define OCCL_WORDS_PER_ROW  3
`define OCCL_DEPTH_W        8

`define OCCL_FOCAL_W        8

// cell buffering between projector and merger
`define OCCL_FIFO_DEPTH     8
`define OCCL_PIPE_SLACK     4   // anchors in flight from read to push

`endif

//--- list.f
+incdir+hdl
hdl/occl_pkg.sv
hdl/anchor_fetch.sv
hdl/anchor_project.sv
hdl/cell_fifo.sv
hdl/depth_merge.sv
hdl/occl_grid_top.sv
verif/occl_mem_models.sv
verif/occl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the occl_tb simulation with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module occl_tb -f list.f -o occl_sim &&
    ./obj_dir/occl_sim | tee sim.log ||
    echo "build or run of the simulation failed"
grep -qx "TB PASSED" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- verif/occl_mem_models.sv
// behavioral anchor and block srams with one cycle read latency for the occlusion grid testbench
`timescale 1ns/100ps
`include "occl_settings.svh"

module anchor_sram (
    input  logic                   clk,
    input  logic                   cen_n_i,
    input  occl_pkg::anchor_addr_t addr_i,
    output occl_pkg::anchor_t      data_o
);
    import occl_pkg::*;

    anchor_t mem [1 << `OCCL_ANCHOR_AW];  // preloaded by the testbench

    always_ff @(posedge clk) begin
        if (!cen_n_i) begin
            data_o <= mem[addr_i];
        end
    end

endmodule

module block_sram (
    input  logic                  clk,
    input  logic                  clr_i,
    input  occl_pkg::blk_req_t    req_i,
    output occl_pkg::block_word_t rdata_o
);
    import occl_pkg::*;

    block_word_t mem [1 << `OCCL_BLOCK_AW];  // peeked by the testbench

    always_ff @(posedge clk) begin
        if (clr_i) begin
            for (int i = 0; i < (1 << `OCCL_BLOCK_AW); i++) begin
                mem[i] <= '0;
            end
        end else if (!req_i.cen_n) begin
            if (req_i.wen) begin
                mem[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem[req_i.addr];
            end
        end
    end

endmodule

//--- verif/occl_tb.sv
// occlusion grid testbench: directed tests checked against a software model of the grid
`timescale 1ns/100ps
`include "occl_settings.svh"

module occl_tb;
    import occl_pkg::*;

    localparam int SEED       = 55172;
    localparam int MAX_CYCLES = 4000;  // ~2.5 cycles per anchor over all tests plus margin
    localparam int WORDS      = `OCCL_GRID_DIM * `OCCL_WORDS_PER_ROW;
    localparam int CELL_W     = `OCCL_DEPTH_W + 1;

    logic         clk = 1'b0;
    logic         rstn;
    logic         start;
    anchor_addr_t addr_start;
    anchor_addr_t addr_end;
    focal_t       focal;
    logic         anchor_cen_n;
    anchor_addr_t anchor_addr;
    anchor_t      anchor_data;
    blk_req_t     blk_req;
    block_word_t  blk_rdata;
    logic         busy;
    logic         done;

    anchor_t      anchors [1 << `OCCL_ANCHOR_AW];  // copy of what sits in the anchor sram
    block_word_t  model [WORDS];
    int           errors;
    int           passed;
    int           failed;
    int           accepts;
    int           mon_lo;
    int           mon_hi;
    int           cycles = 0;
    int           reads = 0;
    int           stray = 0;
    int           writes = 0;
    int           pulses = 0;
    int           max_fill = 0;

    occl_grid_top uut (
        .clk            (clk),
        .rstn           (rstn),
        .start_i        (start),
        .addr_start_i   (addr_start),
        .addr_end_i     (addr_end),
        .focal_i        (focal),
        .anchor_cen_n_o (anchor_cen_n),
        .anchor_addr_o  (anchor_addr),
        .anchor_data_i  (anchor_data),
        .blk_req_o      (blk_req),
        .blk_rdata_i    (blk_rdata),
        .busy_o         (busy),
        .done_o         (done)
    );

    anchor_sram u_anchor_mem (
        .clk     (clk),
        .cen_n_i (anchor_cen_n),
        .addr_i  (anchor_addr),
        .data_o  (anchor_data)
    );

    block_sram u_blk_mem (
        .clk     (clk),
        .clr_i   (!rstn),
        .req_i   (blk_req),
        .rdata_o (blk_rdata)
    );

    always #20 clk = ~clk;

    // per-run activity counters, cleared by the start pulse
    always @(posedge clk) begin
        cycles++;
        if (start) begin
            reads = 0;
            stray = 0;
            writes = 0;
            pulses = 0;
            max_fill = 0;
        end else begin
            if (!anchor_cen_n) begin
                reads++;
                if (int'(anchor_addr) < mon_lo || int'(anchor_addr) > mon_hi) stray++;
            end
            if (!blk_req.cen_n && blk_req.wen) writes++;
            if (done) pulses++;
            if (int'(uut.fifo_count) > max_fill) max_fill = int'(uut.fifo_count);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic coord_t to_sm(input int v);
        int mag;
        mag = (v < 0) ? -v : v;
        return {v < 0, mag[14:0]};
    endfunction

    // coordinates in 1/64 units
    function automatic anchor_t make_anchor(input int x, input int y, input int z);
        anchor_t a;
        a.x = to_sm(x);
        a.y = to_sm(y);
        a.z = to_sm(z);
        return a;
    endfunction

    function automatic anchor_t random_anchor();
        int x;
        int y;
        int z;
        z = int'($urandom_range(40, 1)) * 64 + int'($urandom_range(63, 0));
        x = int'($urandom_range(511, 0));
        y = int'($urandom_range(511, 0));
        if ($urandom_range(1, 0) == 1) x = -x;
        if ($urandom_range(1, 0) == 1) y = -y;
        return make_anchor(x, y, z);
    endfunction

    task automatic load_anchor(input int addr, input anchor_t a);
        anchors[addr] = a;
        u_anchor_mem.mem[addr] = a;
    endtask

    // projection, rejection and nearest-depth merge on the model grid
    task automatic model_merge(input anchor_t a);
        int mz;
        int qx;
        int qy;
        int col;
        int row;
        int bin;
        int w;
        int lane;
        logic [CELL_W-1:0] old;
        mz  = int'(a.z[14:0]);
        if (mz == 0) return;
        qx  = int'(a.x[14:0]) * int'(focal) / mz;
        qy  = int'(a.y[14:0]) * int'(focal) / mz;
        col = a.x[15] ? `OCCL_GRID_CENTER - qx : `OCCL_GRID_CENTER + qx;
        row = a.y[15] ? `OCCL_GRID_CENTER - qy : `OCCL_GRID_CENTER + qy;
        bin = mz >> `OCCL_FRAC_W;
        if (col < 0 || col >= `OCCL_GRID_DIM || row < 0 || row >= `OCCL_GRID_DIM) return;
        if (bin < 1 || bin > 255) return;
        accepts++;
        w    = row * `OCCL_WORDS_PER_ROW + col / `OCCL_LANES;
        lane = col % `OCCL_LANES;
        old  = model[w][lane*CELL_W +: CELL_W];
        if (!old[CELL_W-1] || bin < int'(old[CELL_W-2:0])) begin
            model[w][lane*CELL_W +: CELL_W] = {1'b1, bin[7:0]};
        end
    endtask

    task automatic compare_grid();
        for (int i = 0; i < WORDS; i++) begin
            if (u_blk_mem.mem[i] !== model[i]) begin
                report($sformatf("word %0d is %h, expected %h", i, u_blk_mem.mem[i], model[i]));
            end
        end
    endtask

    // one pass over first..last, then all the per-run checks
    task automatic run_range(input int first, input int last);
        mon_lo  = first;
        mon_hi  = last;
        accepts = 0;
        @(posedge clk);
        #2;
        addr_start = anchor_addr_t'(first);
        addr_end   = anchor_addr_t'(last);
        start      = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        for (int a = first; a <= last; a++) begin
            model_merge(anchors[a]);
        end
        if (done || busy) report("done_o or busy_o still high a cycle after done");
        if (pulses != 1) report($sformatf("%0d done pulses, expected 1", pulses));
        if (reads != last - first + 1) report($sformatf("%0d anchor reads, expected %0d",
                                                        reads, last - first + 1));
        if (stray != 0) report($sformatf("%0d reads outside %0d..%0d", stray, first, last));
        if (writes != accepts) report($sformatf("%0d block writes, expected %0d",
                                                writes, accepts));
        compare_grid();
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic test_single_anchor();
        int e0;
        e0 = errors;
        if (anchor_cen_n !== 1'b1 || blk_req.cen_n !== 1'b1 || blk_req.wen !== 1'b0) begin
            report("sram requests not idle after reset");
        end
        if (done !== 1'b0 || busy !== 1'b0) report("done_o or busy_o high after reset");
        load_anchor(0, make_anchor(128, -64, 256));  // col 14, row 8, bin 4
        run_range(0, 0);
        if (u_blk_mem.mem[26] !== 64'h104) report("single anchor not in word 26 lane 0");
        end_test("single anchor", e0);
    endtask

    task automatic test_same_cell();
        int e0;
        e0 = errors;
        load_anchor(10, make_anchor(-192, 0, 512));  // word 31 lane 0, bin 8
        load_anchor(11, make_anchor(0, 0, 1280));    // word 31 lane 3, far first
        load_anchor(12, make_anchor(0, 0, 384));
        load_anchor(13, make_anchor(0, 64, 512));    // word 34 lane 3, near first
        load_anchor(14, make_anchor(0, 128, 1024));
        run_range(10, 14);
        if (u_blk_mem.mem[31] !== 64'h0000_0008_3000_0108) report("word 31 wrong after merge");
        if (u_blk_mem.mem[34] !== 64'h0000_0008_4000_0000) report("word 34 wrong after merge");
        end_test("same cell", e0);
    endtask

    task automatic test_rejects();
        int e0;
        e0 = errors;
        load_anchor(20, make_anchor(1280, 0, 64));   // right of the grid
        load_anchor(21, make_anchor(0, -1280, 64));  // above the grid
        load_anchor(22, make_anchor(0, 0, 0));
        load_anchor(23, make_anchor(0, 0, 19200));   // bin 300
        load_anchor(24, make_anchor(0, 0, 32));      // bin 0
        run_range(20, 24);
        end_test("rejects", e0);
    endtask

    task automatic test_random_stream();
        int e0;
        e0 = errors;
        for (int a = 100; a < 140; a++) begin
            load_anchor(a, random_anchor());
        end
        run_range(100, 139);
        if (max_fill < `OCCL_FIFO_DEPTH - `OCCL_PIPE_SLACK) begin
            report($sformatf("fifo peaked at %0d, never reached back-pressure", max_fill));
        end
        end_test("random stream", e0);
    endtask

    task automatic test_sub_range();
        int e0;
        e0 = errors;
        for (int a = 0; a < 16; a++) begin
            load_anchor(a, random_anchor());
        end
        run_range(5, 9);
        repeat (6) @(posedge clk);
        #2;
        if (pulses != 1 || busy) report("extra done pulse or busy_o back high after the run");
        end_test("sub range", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        rstn       = 1'b0;
        start      = 1'b0;
        addr_start = '0;
        addr_end   = '0;
        focal      = 8'd8;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        accepts    = 0;
        mon_lo     = 0;
        mon_hi     = 0;
        for (int i = 0; i < WORDS; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        test_single_anchor();
        test_same_cell();
        test_rejects();
        test_random_stream();
        test_sub_range();
        $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
